// ==== id_ser_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI read ID serializer package
// Port widths, AR/R channel structs and slot state encoding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package id_ser_pkg;

  // Channel field widths
  localparam int unsigned SlvIdWidth = 4;
  localparam int unsigned MstIdWidth = 2;
  localparam int unsigned AddrWidth  = 16;
  localparam int unsigned DataWidth  = 16;
  localparam int unsigned LenWidth   = 4;

  // Default serializer configuration
  localparam int unsigned DefMaxUniqIds      = 4;
  localparam int unsigned DefMaxTxnsPerId    = 4;
  localparam int unsigned DefMstIdBaseOffset = 0;

  // AR channel seen on the slave port
  typedef struct packed {
    logic [SlvIdWidth-1:0] id;
    logic [AddrWidth-1:0]  addr;
    logic [LenWidth-1:0]   len;
  } slv_ar_t;

  // AR channel on the master port, narrowed ID
  typedef struct packed {
    logic [MstIdWidth-1:0] id;
    logic [AddrWidth-1:0]  addr;
    logic [LenWidth-1:0]   len;
  } mst_ar_t;

  // R channel returned on the slave port
  typedef struct packed {
    logic [SlvIdWidth-1:0] id;
    logic [DataWidth-1:0]  data;
    logic [1:0]            resp;
    logic                  last;
  } slv_r_t;

  // R channel coming from the master port
  typedef struct packed {
    logic [MstIdWidth-1:0] id;
    logic [DataWidth-1:0]  data;
    logic [1:0]            resp;
    logic                  last;
  } mst_r_t;

  // Per-slot serializer state
  typedef enum logic {
    SLOT_IDLE = 1'b0,
    SLOT_BUSY = 1'b1
  } slot_state_e;

endpackage

// ==== txn_counter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// In-flight read counter for one master ID slot
// Up/down count with full and empty flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module txn_counter #(
  parameter int unsigned MaxCount = id_ser_pkg::DefMaxTxnsPerId
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic inc_i,
  input  logic dec_i,
  output logic full_o,
  output logic empty_o
);

  // Wide enough to hold MaxCount itself
  localparam int unsigned CntWidth = $clog2(MaxCount + 1);

  logic [CntWidth-1:0] cnt_q;

  // Simultaneous inc and dec cancel out
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (inc_i && !dec_i) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (dec_i && !inc_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign full_o  = (cnt_q == CntWidth'(MaxCount));
  assign empty_o = (cnt_q == '0);

  // Slot must stall new ARs once the limit is reached
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    full_o |-> !(inc_i && !dec_i))
    else $error("txn_counter: increment while full");

  // A retiring read must have been issued first
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    empty_o |-> !(dec_i && !inc_i))
    else $error("txn_counter: decrement while empty");

endmodule

// ==== id_ser_slot_fsm.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serializer slot for one master ID
// Admits ARs of a single slave ID at a time and keeps that ID for R
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module id_ser_slot_fsm #(
  parameter int unsigned MaxTxnsPerId = id_ser_pkg::DefMaxTxnsPerId
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              ar_req_i,
  input  logic [id_ser_pkg::SlvIdWidth-1:0] ar_slv_id_i,
  input  logic                              ar_fire_i,
  input  logic                              r_last_fire_i,
  output logic                              ar_grant_o,
  output logic [id_ser_pkg::SlvIdWidth-1:0] slv_id_o
);

  import id_ser_pkg::*;

  slot_state_e           state_q, state_d;
  logic [SlvIdWidth-1:0] slv_id_q;
  logic                  cnt_full;
  logic                  cnt_empty;
  logic                  same_id;
  logic                  slot_free;

  // Outstanding reads of the current owner
  txn_counter #(
    .MaxCount ( MaxTxnsPerId )
  ) i_txn_counter (
    .clk_i   ( clk_i         ),
    .rst_n_i ( rst_n_i       ),
    .inc_i   ( ar_fire_i     ),
    .dec_i   ( r_last_fire_i ),
    .full_o  ( cnt_full      ),
    .empty_o ( cnt_empty     )
  );

  assign same_id = (slv_id_q == ar_slv_id_i);

  // Only an idle slot may change owner
  assign slot_free = (state_q == SLOT_IDLE);

  // Grant is purely combinational on the request
  assign ar_grant_o = ar_req_i && (slot_free || (same_id && !cnt_full));

  // Owner ID for routing R beats back
  assign slv_id_o = slv_id_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      SLOT_IDLE: begin
        if (ar_fire_i) begin
          state_d = SLOT_BUSY;
        end
      end
      SLOT_BUSY: begin
        // Nothing left in flight and no new owner
        if (cnt_empty && !ar_fire_i) begin
          state_d = SLOT_IDLE;
        end
      end
      default: state_d = SLOT_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= SLOT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Owner ID reloaded on every accepted AR
  always_ff @(posedge clk_i) begin
    if (ar_fire_i) begin
      slv_id_q <= ar_slv_id_i;
    end
  end

  // Master side must not close a burst that this slot never issued
  a_no_r_when_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == SLOT_IDLE) |-> !r_last_fire_i)
    else $error("id_ser_slot_fsm: R last beat on idle slot");

endmodule

// ==== ar_spill_reg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-entry spill register for the master AR channel
// Cuts the ready path while keeping full throughput
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module ar_spill_reg (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                valid_i,
  output logic                ready_o,
  input  id_ser_pkg::mst_ar_t data_i,
  output logic                valid_o,
  input  logic                ready_i,
  output id_ser_pkg::mst_ar_t data_o
);

  import id_ser_pkg::*;

  // Entry A takes input, entry B holds what A could not hand off
  mst_ar_t a_data_q;
  mst_ar_t b_data_q;
  logic    a_full_q;
  logic    b_full_q;
  logic    a_fill;
  logic    a_drain;
  logic    b_fill;
  logic    b_drain;

  assign a_fill  = valid_i && ready_o;
  // A is presented at the output whenever B is empty
  assign a_drain = a_full_q && !b_full_q;
  // Unaccepted A moves into B
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill) begin
        a_full_q <= 1'b1;
      end else if (a_drain) begin
        a_full_q <= 1'b0;
      end
      if (b_fill) begin
        b_full_q <= 1'b1;
      end else if (b_drain) begin
        b_full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // Ready only looks at local fill state
  assign ready_o = !a_full_q || !b_full_q;
  assign valid_o = a_full_q || b_full_q;
  // B is always older than A
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && !ready_i) |=> (valid_o && $stable(data_o)))
    else $error("ar_spill_reg: AR payload changed while stalled");

endmodule

// ==== id_ser_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI read-channel ID serializer
// Folds slave IDs onto a few master ID slots, serializing shared slots,
// and restores the slave ID on the way back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module id_ser_top #(
  parameter int unsigned MaxUniqIds      = id_ser_pkg::DefMaxUniqIds,
  parameter int unsigned MaxTxnsPerId    = id_ser_pkg::DefMaxTxnsPerId,
  parameter int unsigned MstIdBaseOffset = id_ser_pkg::DefMstIdBaseOffset
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Slave AR
  input  id_ser_pkg::slv_ar_t slv_ar_i,
  input  logic                slv_ar_valid_i,
  output logic                slv_ar_ready_o,
  // Slave R
  output id_ser_pkg::slv_r_t  slv_r_o,
  output logic                slv_r_valid_o,
  input  logic                slv_r_ready_i,
  // Master AR
  output id_ser_pkg::mst_ar_t mst_ar_o,
  output logic                mst_ar_valid_o,
  input  logic                mst_ar_ready_i,
  // Master R
  input  id_ser_pkg::mst_r_t  mst_r_i,
  input  logic                mst_r_valid_i,
  output logic                mst_r_ready_o
);

  import id_ser_pkg::*;

  logic [MstIdWidth-1:0] ar_sel;
  logic [MaxUniqIds-1:0] ar_req;
  logic [MaxUniqIds-1:0] ar_grant;
  logic [MaxUniqIds-1:0] ar_fire;
  logic [MaxUniqIds-1:0] r_last_fire;
  logic [SlvIdWidth-1:0] slot_slv_id [MaxUniqIds];
  logic [SlvIdWidth-1:0] r_slv_id;
  logic                  sel_grant;
  logic                  spill_ready;
  logic                  ar_hs;
  logic                  r_last_hs;
  mst_ar_t               spill_in;

  // Slot index is (slave ID + offset) mod number of slots
  always_comb begin
    int unsigned slot_idx;
    slot_idx = (32'(slv_ar_i.id) + MstIdBaseOffset) % MaxUniqIds;
    ar_sel   = MstIdWidth'(slot_idx);
  end

  // Grants are already qualified by the per-slot request
  assign sel_grant      = |ar_grant;
  assign slv_ar_ready_o = sel_grant && spill_ready;
  assign ar_hs          = slv_ar_valid_i && slv_ar_ready_o;

  // R passes straight through, only the ID is swapped
  assign slv_r_valid_o = mst_r_valid_i;
  assign mst_r_ready_o = slv_r_ready_i;
  assign r_last_hs     = mst_r_valid_i && slv_r_ready_i && mst_r_i.last;

  for (genvar i = 0; i < MaxUniqIds; i++) begin : gen_slots
    // Only the addressed slot sees a request
    assign ar_req[i]      = slv_ar_valid_i && (ar_sel == MstIdWidth'(i));
    assign ar_fire[i]     = ar_hs && (ar_sel == MstIdWidth'(i));
    // Burst retires on its last beat
    assign r_last_fire[i] = r_last_hs && (mst_r_i.id == MstIdWidth'(i));

    id_ser_slot_fsm #(
      .MaxTxnsPerId ( MaxTxnsPerId )
    ) i_slot (
      .clk_i         ( clk_i          ),
      .rst_n_i       ( rst_n_i        ),
      .ar_req_i      ( ar_req[i]      ),
      .ar_slv_id_i   ( slv_ar_i.id    ),
      .ar_fire_i     ( ar_fire[i]     ),
      .r_last_fire_i ( r_last_fire[i] ),
      .ar_grant_o    ( ar_grant[i]    ),
      .slv_id_o      ( slot_slv_id[i] )
    );
  end

  // Stored owner ID of the slot named by the R beat
  always_comb begin
    r_slv_id = '0;
    for (int unsigned i = 0; i < MaxUniqIds; i++) begin
      if (mst_r_i.id == MstIdWidth'(i)) begin
        r_slv_id = slot_slv_id[i];
      end
    end
  end

  always_comb begin
    slv_r_o.id   = r_slv_id;
    slv_r_o.data = mst_r_i.data;
    slv_r_o.resp = mst_r_i.resp;
    slv_r_o.last = mst_r_i.last;
  end

  // Rebuilt AR with the slot number as master ID
  always_comb begin
    spill_in.id   = ar_sel;
    spill_in.addr = slv_ar_i.addr;
    spill_in.len  = slv_ar_i.len;
  end

  ar_spill_reg i_ar_spill_reg (
    .clk_i   ( clk_i                     ),
    .rst_n_i ( rst_n_i                   ),
    .valid_i ( slv_ar_valid_i && sel_grant ),
    .ready_o ( spill_ready               ),
    .data_i  ( spill_in                  ),
    .valid_o ( mst_ar_valid_o            ),
    .ready_i ( mst_ar_ready_i            ),
    .data_o  ( mst_ar_o                  )
  );

  // Accepted AR shows up on the master port one cycle later
  a_ar_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ar_hs |=> mst_ar_valid_o)
    else $error("id_ser_top: accepted AR missing on master port");

  // Master must only answer with IDs this block can issue
  a_r_id_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_r_valid_i |-> (32'(mst_r_i.id) < MaxUniqIds))
    else $error("id_ser_top: R ID %0h out of slot range", mst_r_i.id);

endmodule

// ==== tb_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Checker for the AXI read ID serializer testbench
// Tracks reads across both DUT ports and counts value and protocol errors
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_checker #(
  parameter int unsigned NumSlots     = id_ser_pkg::DefMaxUniqIds,
  parameter int unsigned MaxTxnsPerId = id_ser_pkg::DefMaxTxnsPerId
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  id_ser_pkg::slv_ar_t               slv_ar_i,
  input  logic                              slv_ar_valid_i,
  input  logic                              slv_ar_ready_i,
  input  logic [id_ser_pkg::MstIdWidth-1:0] exp_mst_id_i,
  input  id_ser_pkg::slv_r_t                slv_r_i,
  input  logic                              slv_r_valid_i,
  input  logic                              slv_r_ready_i,
  input  id_ser_pkg::mst_ar_t               mst_ar_i,
  input  logic                              mst_ar_valid_i,
  input  logic                              mst_ar_ready_i,
  input  id_ser_pkg::mst_r_t                mst_r_i,
  input  logic                              mst_r_valid_i,
  input  logic                              mst_r_ready_i,
  output int unsigned                       val_errs_o,
  output int unsigned                       proto_errs_o,
  output int unsigned                       done_o
);

  import id_ser_pkg::*;

  localparam int unsigned Depth = 8;

  // Accepted on the slave port but not yet issued on the master port
  slv_ar_t               acc_ar_q [$];
  logic [MstIdWidth-1:0] acc_mid_q [$];
  // Issued reads per master ID with the oldest first
  slv_ar_t               out_ar [NumSlots][Depth];
  int unsigned           out_head [NumSlots];
  int unsigned           out_tail [NumSlots];
  int unsigned           out_fill [NumSlots];
  int unsigned           out_beat [NumSlots];
  logic                  started;
  logic                  ar_stall;
  mst_ar_t               ar_held;
  int unsigned           val_errs = 0;
  int unsigned           proto_errs = 0;
  int unsigned           done_cnt = 0;

  assign val_errs_o   = val_errs;
  assign proto_errs_o = proto_errs;
  assign done_o       = done_cnt;

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      val_errs++;
      $display("[FAIL] %0t %s exp=0x%0h got=0x%0h", $time, name, exp, got);
    end
  endtask

  task automatic report(input string what);
    proto_errs++;
    $display("ERROR %0t %s", $time, what);
  endtask

  always @(posedge clk_i) begin
    slv_ar_t               exp_ar;
    logic [MstIdWidth-1:0] exp_mid;
    int unsigned           s;
    if (!rst_n_i) begin
      started  = 1'b0;
      ar_stall = 1'b0;
      for (int k = 0; k < NumSlots; k++) begin
        out_head[k] = 0;
        out_tail[k] = 0;
        out_fill[k] = 0;
        out_beat[k] = 0;
      end
    end else begin
      // Reset state holds until the first AR shows up
      if (slv_ar_valid_i) started = 1'b1;
      if (!started && mst_ar_valid_i) report("mst_ar_valid_o high before any AR was driven");
      if (!started && slv_r_valid_i) report("slv_r_valid_o high before any AR was driven");
      // R path is a straight wire
      check_val("slv_r_valid_o", mst_r_valid_i, slv_r_valid_i);
      check_val("mst_r_ready_o", slv_r_ready_i, mst_r_ready_i);
      // Stalled master AR must hold
      if (ar_stall && (!mst_ar_valid_i || mst_ar_i != ar_held)) begin
        report("master AR dropped or changed before mst_ar_ready_i");
      end
      ar_stall = mst_ar_valid_i && !mst_ar_ready_i;
      ar_held  = mst_ar_i;
      if (slv_ar_valid_i && slv_ar_ready_i) begin
        acc_ar_q.push_back(slv_ar_i);
        acc_mid_q.push_back(exp_mst_id_i);
      end
      if (mst_ar_valid_i && mst_ar_ready_i) begin
        if (acc_ar_q.size() == 0) begin
          report("master AR issued with no slave AR accepted");
        end else begin
          exp_ar  = acc_ar_q.pop_front();
          exp_mid = acc_mid_q.pop_front();
          check_val("mst_ar_o.id", exp_mid, mst_ar_i.id);
          check_val("mst_ar_o.addr", exp_ar.addr, mst_ar_i.addr);
          check_val("mst_ar_o.len", exp_ar.len, mst_ar_i.len);
          s = mst_ar_i.id;
          if (out_fill[s] >= MaxTxnsPerId) begin
            report($sformatf("more than %0d reads in flight on master ID %0d", MaxTxnsPerId, s));
          end
          if (out_fill[s] != 0 && out_ar[s][out_head[s]].id != exp_ar.id) begin
            report($sformatf("slave ID %0h issued on master ID %0d while slave ID %0h in flight",
                             exp_ar.id, s, out_ar[s][out_head[s]].id));
          end
          if (out_fill[s] < Depth) begin
            out_ar[s][out_tail[s]] = exp_ar;
            out_tail[s] = (out_tail[s] + 1) % Depth;
            out_fill[s]++;
          end
        end
      end
      // Beat belongs to the oldest burst of its master ID
      if (slv_r_valid_i && slv_r_ready_i) begin
        s = mst_r_i.id;
        if (out_fill[s] == 0) begin
          report($sformatf("extra R beat on master ID %0d with no read outstanding", s));
        end else begin
          exp_ar = out_ar[s][out_head[s]];
          check_val("slv_r_o.id", exp_ar.id, slv_r_i.id);
          check_val("slv_r_o.data", DataWidth'(exp_ar.addr + out_beat[s]), slv_r_i.data);
          check_val("slv_r_o.resp", 2'b00, slv_r_i.resp);
          check_val("slv_r_o.last", out_beat[s] == exp_ar.len, slv_r_i.last);
          if (out_beat[s] == exp_ar.len) begin
            out_beat[s] = 0;
            out_head[s] = (out_head[s] + 1) % Depth;
            out_fill[s]--;
            done_cnt++;
          end else begin
            out_beat[s]++;
          end
        end
      end
    end
  end

endmodule

// ==== tb_id_ser.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the AXI read ID serializer
// Golden-file AR stimulus, random master memory model and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_id_ser;

  import id_ser_pkg::*;

  localparam int unsigned NumReads    = 26;
  localparam int unsigned ClkPeriod   = 40;
  localparam int unsigned ResetCycles = 10;
  localparam int unsigned DriveDelay  = 2;
  localparam int unsigned Depth       = 8;
  localparam int unsigned NumSlots    = DefMaxUniqIds;
  localparam int unsigned MaxTxns     = DefMaxTxnsPerId;
  localparam int unsigned BaseOffset  = DefMstIdBaseOffset;
  localparam logic [31:0] Seed        = 32'h4663ee83;

  logic                  clk = 1'b0;
  logic                  rst_n;
  integer                seed;
  logic [15:0]           golden [NumReads*4];
  slv_ar_t               slv_ar;
  logic                  slv_ar_valid;
  logic                  slv_ar_ready;
  logic [MstIdWidth-1:0] exp_mst_id;
  slv_r_t                slv_r;
  logic                  slv_r_valid;
  logic                  slv_r_ready = 1'b0;
  mst_ar_t               mst_ar;
  logic                  mst_ar_valid;
  logic                  mst_ar_ready = 1'b0;
  mst_r_t                mst_r = '0;
  logic                  mst_r_valid = 1'b0;
  logic                  mst_r_ready;
  int unsigned           val_errs;
  int unsigned           proto_errs;
  int unsigned           done_cnt;
  // Memory model keeps one FIFO of bursts per master ID
  logic [AddrWidth-1:0]  mem_addr [NumSlots][Depth];
  logic [LenWidth-1:0]   mem_len [NumSlots][Depth];
  int unsigned           mem_head [NumSlots];
  int unsigned           mem_tail [NumSlots];
  int unsigned           mem_fill [NumSlots];
  int unsigned           mem_beat [NumSlots];

  always #(ClkPeriod/2) clk = ~clk;

  id_ser_top #(
    .MaxUniqIds      ( NumSlots   ),
    .MaxTxnsPerId    ( MaxTxns    ),
    .MstIdBaseOffset ( BaseOffset )
  ) DUT (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .slv_ar_i       ( slv_ar       ),
    .slv_ar_valid_i ( slv_ar_valid ),
    .slv_ar_ready_o ( slv_ar_ready ),
    .slv_r_o        ( slv_r        ),
    .slv_r_valid_o  ( slv_r_valid  ),
    .slv_r_ready_i  ( slv_r_ready  ),
    .mst_ar_o       ( mst_ar       ),
    .mst_ar_valid_o ( mst_ar_valid ),
    .mst_ar_ready_i ( mst_ar_ready ),
    .mst_r_i        ( mst_r        ),
    .mst_r_valid_i  ( mst_r_valid  ),
    .mst_r_ready_o  ( mst_r_ready  )
  );

  tb_checker #(
    .NumSlots     ( NumSlots ),
    .MaxTxnsPerId ( MaxTxns  )
  ) u_checker (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .slv_ar_i       ( slv_ar       ),
    .slv_ar_valid_i ( slv_ar_valid ),
    .slv_ar_ready_i ( slv_ar_ready ),
    .exp_mst_id_i   ( exp_mst_id   ),
    .slv_r_i        ( slv_r        ),
    .slv_r_valid_i  ( slv_r_valid  ),
    .slv_r_ready_i  ( slv_r_ready  ),
    .mst_ar_i       ( mst_ar       ),
    .mst_ar_valid_i ( mst_ar_valid ),
    .mst_ar_ready_i ( mst_ar_ready ),
    .mst_r_i        ( mst_r        ),
    .mst_r_valid_i  ( mst_r_valid  ),
    .mst_r_ready_i  ( mst_r_ready  ),
    .val_errs_o     ( val_errs     ),
    .proto_errs_o   ( proto_errs   ),
    .done_o         ( done_cnt     )
  );

  // Master memory model samples at the edge and drives just after it
  always @(posedge clk) begin
    logic        in_rst;
    logic        r_hs;
    logic        found;
    logic [31:0] rnd;
    int unsigned k;
    in_rst = !rst_n;
    r_hs   = mst_r_valid && mst_r_ready;
    if (in_rst) begin
      for (int n = 0; n < NumSlots; n++) begin
        mem_head[n] = 0;
        mem_tail[n] = 0;
        mem_fill[n] = 0;
        mem_beat[n] = 0;
      end
    end else begin
      if (mst_ar_valid && mst_ar_ready) begin
        k = mst_ar.id;
        mem_addr[k][mem_tail[k]] = mst_ar.addr;
        mem_len[k][mem_tail[k]]  = mst_ar.len;
        mem_tail[k] = (mem_tail[k] + 1) % Depth;
        mem_fill[k]++;
      end
      // Burst retires on its last beat
      if (r_hs) begin
        k = mst_r.id;
        if (mst_r.last) begin
          mem_beat[k] = 0;
          mem_head[k] = (mem_head[k] + 1) % Depth;
          mem_fill[k]--;
        end else begin
          mem_beat[k]++;
        end
      end
    end
    #DriveDelay;
    rnd          = $random(seed);
    mst_ar_ready = !in_rst && rnd[0];
    slv_r_ready  = !in_rst && (rnd[1] || rnd[2]);
    // Beat holds until taken, then a random ID goes next
    if (in_rst || r_hs || !mst_r_valid) begin
      mst_r_valid = 1'b0;
      found       = 1'b0;
      for (int n = 0; n < NumSlots; n++) begin
        k = (rnd[5:4] + n) % NumSlots;
        if (!in_rst && !found && rnd[7:6] != 2'b00 && mem_fill[k] != 0) begin
          found       = 1'b1;
          mst_r.id    = MstIdWidth'(k);
          mst_r.data  = DataWidth'(mem_addr[k][mem_head[k]] + mem_beat[k]);
          mst_r.resp  = 2'b00;
          mst_r.last  = (mem_beat[k] == mem_len[k][mem_head[k]]);
          mst_r_valid = 1'b1;
        end
      end
    end
  end

  // Golden AR stimulus
  initial begin
    logic [31:0] rnd;
    seed         = Seed;
    rst_n        = 1'b0;
    slv_ar       = '0;
    slv_ar_valid = 1'b0;
    exp_mst_id   = '0;
    $readmemh("golden_reads.txt", golden);
    repeat (ResetCycles) @(posedge clk);
    #DriveDelay;
    rst_n = 1'b1;
    // Idle cycles expose the reset state
    repeat (4) @(posedge clk);
    for (int i = 0; i < NumReads; i++) begin
      #DriveDelay;
      slv_ar.id    = SlvIdWidth'(golden[4*i]);
      slv_ar.addr  = golden[4*i+1];
      slv_ar.len   = LenWidth'(golden[4*i+2]);
      exp_mst_id   = MstIdWidth'(golden[4*i+3]);
      slv_ar_valid = 1'b1;
      @(posedge clk);
      while (!slv_ar_ready) @(posedge clk);
      rnd = $random(seed);
      if (rnd[1:0] == 2'b00) begin
        #DriveDelay;
        slv_ar_valid = 1'b0;
        @(posedge clk);
      end
    end
    #DriveDelay;
    slv_ar_valid = 1'b0;
    wait (done_cnt == NumReads);
    // Drain time to catch stray beats
    repeat (20) @(posedge clk);
    $display("Summary: %0d value errors, %0d protocol errors, %0d of %0d reads completed",
             val_errs, proto_errs, done_cnt, NumReads);
    if (val_errs == 0 && proto_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog sized for the longest bursts with heavy back-pressure
  initial begin
    #(NumReads * 16 * 10 * ClkPeriod);
    $display("Timeout: only %0d of %0d reads completed", done_cnt, NumReads);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== golden_reads.txt ====
// Columns: slave ID, address, burst length (beats minus one), expected master ID
// All hex; expected master ID is (slave ID + 0) mod 4
1 0100 3 1
1 0110 0 1
5 0200 1 1
2 0300 2 2
2 0310 2 2
2 0320 0 2
2 0330 1 2
2 0340 3 2
2 0350 0 2
6 0400 1 2
0 0500 7 0
4 0600 0 0
8 0700 2 0
3 0800 1 3
3 0810 4 3
7 0900 0 3
b 0a00 2 3
9 0b00 1 1
9 0b10 0 1
9 0b20 2 1
9 0b30 1 1
9 0b40 0 1
d 0c00 3 1
e 0d00 f 2
f 0e00 0 3
c 0f00 5 0

// ==== tb.f ====
id_ser_pkg.sv
txn_counter.sv
id_ser_slot_fsm.sv
ar_spill_reg.sv
id_ser_top.sv
tb_checker.sv
tb_id_ser.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_id_ser
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = SOME TESTS FAILED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A crashed simulation counts as a failure
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Result: FAIL"; exit 1; \
	else echo "Result: PASS"; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
